// ==== src/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	//////////////////////////////////////////////////
	// major opcodes
	//////////////////////////////////////////////////
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	localparam logic [6:0] f7_base = 7'b0000000; // add, srl, srli
	localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

	//////////////////////////////////////////////////
	// control codes
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		cls_load    = 4'd0,
		cls_op_imm  = 4'd1,
		cls_auipc   = 4'd2,
		cls_store   = 4'd3,
		cls_op      = 4'd4,
		cls_lui     = 4'd5,
		cls_branch  = 4'd6,
		cls_jalr    = 4'd7,
		cls_jal     = 4'd8,
		cls_illegal = 4'd9
	} op_class_e;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_eq   = 4'd2,
		alu_ltu  = 4'd3,
		alu_lt   = 4'd4,
		alu_and  = 4'd5,
		alu_or   = 4'd6,
		alu_xor  = 4'd7,
		alu_srl  = 4'd8,
		alu_sll  = 4'd9,
		alu_sla  = 4'd10,
		alu_sra  = 4'd11,
		alu_else = 4'd12  // lui and illegal
	} alu_func_e;

	typedef enum logic [2:0] {
		br_none = 3'd0,
		br_eq   = 3'd1,
		br_lt   = 3'd2,
		br_ne   = 3'd3,
		br_ge   = 3'd4,
		br_ltu  = 3'd5,
		br_geu  = 3'd6
	} br_type_e;

	typedef enum logic [2:0] {
		imm_none = 3'd0,
		imm_i    = 3'd1,
		imm_s    = 3'd2,
		imm_sb   = 3'd3,
		imm_u    = 3'd4,
		imm_uj   = 3'd5
	} imm_type_e;

	typedef enum logic [1:0] {
		wd_alu = 2'd0,
		wd_pc4 = 2'd1,
		wd_mem = 2'd2,
		wd_imm = 2'd3
	} wd_sel_e;

	typedef enum logic {
		src1_rd0 = 1'b0,
		src1_pc  = 1'b1
	} src1_sel_e;

	typedef enum logic {
		src2_rd1 = 1'b0,
		src2_imm = 1'b1
	} src2_sel_e;

	typedef enum logic [2:0] {
		rd_w  = 3'd0,
		rd_b  = 3'd1,
		rd_bu = 3'd2,
		rd_h  = 3'd3,
		rd_hu = 3'd4
	} read_type_e;

	typedef enum logic [1:0] {
		wr_w = 2'd0,
		wr_b = 2'd1,
		wr_h = 2'd2
	} write_type_e;

	//////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [6:0]            funct7;
		logic [reg_addr_w-1:0] ra1;
		logic [reg_addr_w-1:0] ra0;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] wa;
	} inst_fields_t;

	typedef struct packed {
		alu_func_e   alu_func;
		br_type_e    br_type;
		read_type_e  read_type;
		write_type_e write_type;
	} funct_ctrl_t;

	typedef struct packed {
		logic        rf_re0;
		logic        rf_re1;
		logic        jal;
		logic        jalr;
		logic        rf_we;
		wd_sel_e     rf_wd_sel;
		src1_sel_e   alu_src1_sel;
		src2_sel_e   alu_src2_sel;
		imm_type_e   imm_type;
		logic        mem_we;
		funct_ctrl_t funct;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== src/op_class_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_class_decoder (
	input  logic [rv_ctrl_pkg::xlen-1:0] inst,
	output rv_ctrl_pkg::op_class_e       op_class,
	output rv_ctrl_pkg::inst_fields_t    fields
);

	import rv_ctrl_pkg::*;

	logic [6:0] opcode;

	assign opcode = inst[6:0];

	//////////////////////////////////////////////////
	// field split
	//////////////////////////////////////////////////
	assign fields.funct7 = inst[31:25];
	assign fields.ra1    = inst[24:20];
	assign fields.ra0    = inst[19:15];
	assign fields.funct3 = inst[14:12];
	assign fields.wa     = inst[11:7];

	//////////////////////////////////////////////////
	// opcode to class
	//////////////////////////////////////////////////
	always_comb
	begin
		case (opcode)
			opc_load:
				op_class = cls_load;
			opc_op_imm:
				op_class = cls_op_imm;
			opc_auipc:
				op_class = cls_auipc;
			opc_store:
				op_class = cls_store;
			opc_op:
				op_class = cls_op;
			opc_lui:
				op_class = cls_lui;
			opc_branch:
				op_class = cls_branch;
			opc_jalr:
				op_class = cls_jalr;
			opc_jal:
				op_class = cls_jal;
			default:
				op_class = cls_illegal; // unknown major opcode
		endcase
	end

endmodule

`default_nettype wire

// ==== src/funct_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module funct_decoder (
	input  rv_ctrl_pkg::op_class_e    op_class,
	input  rv_ctrl_pkg::inst_fields_t fields,
	output rv_ctrl_pkg::funct_ctrl_t  funct,
	output logic                      funct_ok
);

	import rv_ctrl_pkg::*;

	alu_func_e alu_func;
	br_type_e  br_type;

	//////////////////////////////////////////////////
	// alu function and legality
	//////////////////////////////////////////////////
	always_comb
	begin
		alu_func = alu_else;
		funct_ok = 1'b1;
		case (op_class)
			cls_op, cls_op_imm:
			begin
				case (fields.funct3)
					3'b000:
					begin
						if (op_class == cls_op_imm)
							alu_func = alu_add; // addi ignores funct7
						else if (fields.funct7 == f7_base)
							alu_func = alu_add;
						else if (fields.funct7 == f7_alt)
							alu_func = alu_sub;
						else
							funct_ok = 1'b0;
					end
					3'b001:
						alu_func = alu_sll;
					3'b010:
						alu_func = alu_lt;
					3'b011:
						alu_func = alu_ltu;
					3'b100:
						alu_func = alu_xor;
					3'b101:
					begin
						if (fields.funct7 == f7_base)
							alu_func = alu_srl;
						else if (fields.funct7 == f7_alt)
							alu_func = alu_sra;
						else
							funct_ok = 1'b0;
					end
					3'b110:
						alu_func = alu_or;
					default:
						alu_func = alu_and;
				endcase
			end
			cls_load, cls_store, cls_auipc, cls_jal, cls_jalr:
				alu_func = alu_add; // address or pc arithmetic
			cls_branch:
			begin
				alu_func = alu_add;
				if (fields.funct3 == 3'b010 || fields.funct3 == 3'b011)
					funct_ok = 1'b0;
			end
			cls_lui:
				alu_func = alu_else;
			default:
				funct_ok = 1'b0;
		endcase
	end

	always_comb
	begin
		br_type = br_none;
		if (op_class == cls_branch)
		begin
			case (fields.funct3)
				3'b000: br_type = br_eq;
				3'b001: br_type = br_ne;
				3'b100: br_type = br_lt;
				3'b101: br_type = br_ge;
				3'b110: br_type = br_ltu;
				3'b111: br_type = br_geu;
				default: br_type = br_none;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// memory access widths
	//////////////////////////////////////////////////
	always_comb
	begin
		funct.read_type = rd_w;
		if (op_class == cls_load)
		begin
			case (fields.funct3)
				3'b000: funct.read_type = rd_b;
				3'b001: funct.read_type = rd_h;
				3'b100: funct.read_type = rd_bu;
				3'b101: funct.read_type = rd_hu;
				default: funct.read_type = rd_w; // lw and unlisted codes
			endcase
		end
		funct.write_type = wr_w;
		if (op_class == cls_store)
		begin
			case (fields.funct3)
				3'b000: funct.write_type = wr_b;
				3'b001: funct.write_type = wr_h;
				default: funct.write_type = wr_w;
			endcase
		end
	end

	// illegal encodings carry the fall-back codes
	assign funct.alu_func = funct_ok ? alu_func : alu_else;
	assign funct.br_type  = br_type;

endmodule

`default_nettype wire

// ==== src/ctrl_signal_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_signal_gen (
	input  rv_ctrl_pkg::op_class_e    op_class,
	input  rv_ctrl_pkg::inst_fields_t fields,
	input  rv_ctrl_pkg::funct_ctrl_t  funct,
	input  logic                      funct_ok,
	output rv_ctrl_pkg::ctrl_t        next_ctrl
);

	import rv_ctrl_pkg::*;

	logic ra0_nz;
	logic ra1_nz;
	logic wa_nz;

	// x0 never read or written
	assign ra0_nz = |fields.ra0;
	assign ra1_nz = |fields.ra1;
	assign wa_nz  = |fields.wa;

	assign next_ctrl.funct = funct;

	//////////////////////////////////////////////////
	// per-class control bits
	//////////////////////////////////////////////////
	always_comb
	begin
		next_ctrl.rf_re0       = 1'b0; // fall-back word
		next_ctrl.rf_re1       = 1'b0;
		next_ctrl.jal          = 1'b0;
		next_ctrl.jalr         = 1'b0;
		next_ctrl.rf_we        = 1'b0;
		next_ctrl.rf_wd_sel    = wd_mem;
		next_ctrl.alu_src1_sel = src1_rd0;
		next_ctrl.alu_src2_sel = src2_imm;
		next_ctrl.imm_type     = imm_none;
		next_ctrl.mem_we       = 1'b0;
		if (funct_ok)
		begin
			case (op_class)
				cls_load:
				begin
					next_ctrl.rf_re0   = ra0_nz;
					next_ctrl.rf_we    = wa_nz;
					next_ctrl.imm_type = imm_i;
				end
				cls_op_imm:
				begin
					next_ctrl.rf_re0    = ra0_nz;
					next_ctrl.rf_re1    = ra1_nz; // imm bits, kept as decoded
					next_ctrl.rf_we     = wa_nz;
					next_ctrl.rf_wd_sel = wd_alu;
					next_ctrl.imm_type  = imm_i;
				end
				cls_auipc:
				begin
					next_ctrl.rf_we        = wa_nz;
					next_ctrl.rf_wd_sel    = wd_alu;
					next_ctrl.alu_src1_sel = src1_pc;
					next_ctrl.imm_type     = imm_u;
				end
				cls_store:
				begin
					next_ctrl.rf_re0   = ra0_nz;
					next_ctrl.rf_re1   = ra1_nz;
					next_ctrl.imm_type = imm_s;
					next_ctrl.mem_we   = 1'b1;
				end
				cls_op:
				begin
					next_ctrl.rf_re0       = ra0_nz;
					next_ctrl.rf_re1       = ra1_nz;
					next_ctrl.rf_we        = wa_nz;
					next_ctrl.rf_wd_sel    = wd_alu;
					next_ctrl.alu_src2_sel = src2_rd1;
				end
				cls_lui:
				begin
					next_ctrl.rf_we     = wa_nz;
					next_ctrl.rf_wd_sel = wd_imm;
					next_ctrl.imm_type  = imm_u;
				end
				cls_branch:
				begin
					next_ctrl.rf_re0       = ra0_nz;
					next_ctrl.rf_re1       = ra1_nz;
					next_ctrl.alu_src1_sel = src1_pc; // target = pc + imm
					next_ctrl.imm_type     = imm_sb;
				end
				cls_jalr:
				begin
					next_ctrl.rf_re0    = ra0_nz;
					next_ctrl.jalr      = 1'b1;
					next_ctrl.rf_we     = wa_nz;
					next_ctrl.rf_wd_sel = wd_pc4;
					next_ctrl.imm_type  = imm_i;
				end
				cls_jal:
				begin
					next_ctrl.jal          = 1'b1;
					next_ctrl.rf_we        = wa_nz;
					next_ctrl.rf_wd_sel    = wd_pc4;
					next_ctrl.alu_src1_sel = src1_pc;
					next_ctrl.imm_type     = imm_uj;
				end
				default:
					next_ctrl.imm_type = imm_none;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/decode_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic               stall,
	input  rv_ctrl_pkg::ctrl_t next_ctrl,
	output logic               out_valid,
	output rv_ctrl_pkg::ctrl_t ctrl
);

	import rv_ctrl_pkg::*;

	logic accept;

	assign accept = in_valid & ~stall;

	//////////////////////////////////////////////////
	// decode to execute register
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			ctrl      <= '0;
		end
		else if (!stall)
		begin
			out_valid <= in_valid; // bubble when nothing offered
			if (accept)
				ctrl <= next_ctrl;
		end
	end

endmodule

`default_nettype wire

// ==== src/ctrl_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode_top (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  logic [rv_ctrl_pkg::xlen-1:0] inst,
	input  logic                         stall,
	output logic                         out_valid,
	output rv_ctrl_pkg::ctrl_t           ctrl
);

	import rv_ctrl_pkg::*;

	op_class_e    op_class;
	inst_fields_t fields;
	funct_ctrl_t  funct;
	logic         funct_ok;
	ctrl_t        next_ctrl;

	op_class_decoder u_op_class (
		.inst     (inst),
		.op_class (op_class),
		.fields   (fields)
	);

	funct_decoder u_funct (
		.op_class (op_class),
		.fields   (fields),
		.funct    (funct),
		.funct_ok (funct_ok)
	);

	ctrl_signal_gen u_ctrl_gen (
		.op_class  (op_class),
		.fields    (fields),
		.funct     (funct),
		.funct_ok  (funct_ok),
		.next_ctrl (next_ctrl)
	);

	decode_stage_reg u_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.stall     (stall),
		.next_ctrl (next_ctrl),
		.out_valid (out_valid),
		.ctrl      (ctrl)
	);

endmodule

`default_nettype wire

// ==== tests/ctrl_decode_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode_asserts (
	input logic               clk,
	input logic               rst_n,
	input logic               stall,
	input logic               out_valid,
	input rv_ctrl_pkg::ctrl_t ctrl
);

	int fail_count = 0; // read by the testbench

	//////////////////////////////////////////////////
	// stage register properties
	//////////////////////////////////////////////////
	reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
	else
	begin
		$error("out_valid high in the cycle after reset");
		fail_count++;
	end

	stall_holds_stage: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(out_valid) && $stable(ctrl))
	else
	begin
		$error("stage output changed under stall");
		fail_count++;
	end

	// a store never writes the register file
	no_we_and_mem_we: assert property (@(posedge clk) !(ctrl.rf_we && ctrl.mem_we))
	else
	begin
		$error("rf_we and mem_we both high");
		fail_count++;
	end

endmodule

bind ctrl_decode_top ctrl_decode_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.out_valid (out_valid),
	.ctrl      (ctrl)
);

`default_nettype wire

// ==== tests/ctrl_decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode_tb;

	import rv_ctrl_pkg::*;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic [xlen-1:0] inst;
	logic            stall;
	logic            out_valid;
	ctrl_t           ctrl;

	string       row_name [$];
	logic [31:0] row_inst [$];
	ctrl_t       row_exp [$];

	ctrl_t w_op, w_opi, w_load, w_store, w_br, w_jal, w_jalr, w_lui, w_auipc, w_fb;

	alu_func_e   op_alu [8] = '{alu_add, alu_sll, alu_lt, alu_ltu, alu_xor, alu_srl, alu_or,
		alu_and};
	read_type_e  ld_rd [8]  = '{rd_b, rd_h, rd_w, rd_w, rd_bu, rd_hu, rd_w, rd_w};
	write_type_e st_wr [8]  = '{wr_b, wr_h, wr_w, wr_w, wr_w, wr_w, wr_w, wr_w};

	logic [31:0] lcg_state     = 32'd55518;
	int          checks        = 0;
	int          errors        = 0;
	int          cycles        = 0;
	int          timeout_limit = 0;

	ctrl_decode_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.inst      (inst),
		.stall     (stall),
		.out_valid (out_valid),
		.ctrl      (ctrl)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > timeout_limit)
		begin
			$display("timeout: not every decode row came out after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] ra1,
		input logic [4:0] ra0, input logic [2:0] f3, input logic [4:0] wa, input logic [6:0] opc);
		return {f7, ra1, ra0, f3, wa, opc};
	endfunction

	// en is {rf_re0, rf_re1, jal, jalr, rf_we, mem_we}
	function automatic ctrl_t control_word(input logic [5:0] en, input wd_sel_e wd,
		input src1_sel_e s1, input src2_sel_e s2, input imm_type_e imm);
		ctrl_t w;
		w = '0;
		{w.rf_re0, w.rf_re1, w.jal, w.jalr, w.rf_we, w.mem_we} = en;
		w.rf_wd_sel           = wd;
		w.alu_src1_sel        = s1;
		w.alu_src2_sel        = s2;
		w.imm_type            = imm;
		w.funct.alu_func      = alu_add;
		w.funct.br_type       = br_none;
		w.funct.read_type     = rd_w;
		w.funct.write_type    = wr_w;
		return w;
	endfunction

	function automatic ctrl_t set_funct(input ctrl_t w, input alu_func_e alu, input br_type_e br);
		w.funct.alu_func = alu;
		w.funct.br_type  = br;
		return w;
	endfunction

	function automatic ctrl_t set_width(input ctrl_t w, input read_type_e rd,
		input write_type_e wr);
		w.funct.read_type  = rd;
		w.funct.write_type = wr;
		return w;
	endfunction

	// drop is {ra0, ra1, wa} set to x0
	function automatic ctrl_t drop_enables(input ctrl_t w, input logic [2:0] drop);
		if (drop[2])
			w.rf_re0 = 1'b0;
		if (drop[1])
			w.rf_re1 = 1'b0;
		if (drop[0])
			w.rf_we = 1'b0;
		return w;
	endfunction

	task automatic add_row(input string name, input logic [31:0] word, input ctrl_t exp);
		row_name.push_back(name);
		row_inst.push_back(word);
		row_exp.push_back(exp);
	endtask

	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: ctrl expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAILED %s: out_valid expected %0b actual %0b", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus table and run
	//////////////////////////////////////////////////
	initial
	begin
		int          f3;
		int          idx;
		int          n;
		logic        drv_valid;
		logic        drv_stall;
		logic        exp_valid;
		logic [31:0] rnd;
		ctrl_t       exp_ctrl;
		string       exp_name;

		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		stall    = 1'b0;
		inst     = '0;

		w_op    = control_word(6'b110010, wd_alu, src1_rd0, src2_rd1, imm_none);
		w_opi   = control_word(6'b110010, wd_alu, src1_rd0, src2_imm, imm_i);
		w_load  = control_word(6'b100010, wd_mem, src1_rd0, src2_imm, imm_i);
		w_store = control_word(6'b110001, wd_mem, src1_rd0, src2_imm, imm_s);
		w_br    = control_word(6'b110000, wd_mem, src1_pc, src2_imm, imm_sb);
		w_jal   = control_word(6'b001010, wd_pc4, src1_pc, src2_imm, imm_uj);
		w_jalr  = control_word(6'b100110, wd_pc4, src1_rd0, src2_imm, imm_i);
		w_auipc = control_word(6'b000010, wd_alu, src1_pc, src2_imm, imm_u);
		w_lui   = set_funct(control_word(6'b000010, wd_imm, src1_rd0, src2_imm, imm_u),
			alu_else, br_none);
		w_fb    = set_funct(control_word(6'b000000, wd_mem, src1_rd0, src2_imm, imm_none),
			alu_else, br_none);

		for (f3 = 0; f3 < 8; f3++)
		begin
			add_row($sformatf("op_f3_%0d", f3), encode(7'h00, 5'd2, 5'd1, f3[2:0], 5'd3, opc_op),
				set_funct(w_op, op_alu[f3], br_none));
			add_row($sformatf("opi_f3_%0d", f3),
				encode(7'h00, 5'd2, 5'd1, f3[2:0], 5'd3, opc_op_imm),
				set_funct(w_opi, op_alu[f3], br_none)); // ra1 non-zero raises rf_re1
			add_row($sformatf("load_f3_%0d", f3),
				encode(7'h00, 5'd2, 5'd1, f3[2:0], 5'd3, opc_load), set_width(w_load, ld_rd[f3], wr_w));
			add_row($sformatf("store_f3_%0d", f3),
				encode(7'h00, 5'd2, 5'd1, f3[2:0], 5'd3, opc_store),
				set_width(w_store, rd_w, st_wr[f3]));
		end
		add_row("sub", encode(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, opc_op), set_funct(w_op, alu_sub, br_none));
		add_row("sra", encode(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, opc_op), set_funct(w_op, alu_sra, br_none));
		add_row("srai", encode(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, opc_op_imm),
			set_funct(w_opi, alu_sra, br_none));
		add_row("addi_f7", encode(7'h55, 5'd2, 5'd1, 3'd0, 5'd3, opc_op_imm), w_opi);
		add_row("add_bad_f7", encode(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, opc_op), w_fb);
		add_row("srl_bad_f7", encode(7'h01, 5'd2, 5'd1, 3'd5, 5'd3, opc_op), w_fb);
		add_row("srli_bad_f7", encode(7'h01, 5'd2, 5'd1, 3'd5, 5'd3, opc_op_imm), w_fb);
		add_row("addi_ra1_0", encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd3, opc_op_imm),
			drop_enables(w_opi, 3'b010));
		add_row("beq", encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, opc_branch), set_funct(w_br, alu_add, br_eq));
		add_row("bne", encode(7'h00, 5'd2, 5'd1, 3'd1, 5'd3, opc_branch), set_funct(w_br, alu_add, br_ne));
		add_row("blt", encode(7'h00, 5'd2, 5'd1, 3'd4, 5'd3, opc_branch), set_funct(w_br, alu_add, br_lt));
		add_row("bge", encode(7'h00, 5'd2, 5'd1, 3'd5, 5'd3, opc_branch), set_funct(w_br, alu_add, br_ge));
		add_row("bltu", encode(7'h00, 5'd2, 5'd1, 3'd6, 5'd3, opc_branch),
			set_funct(w_br, alu_add, br_ltu));
		add_row("bgeu", encode(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, opc_branch),
			set_funct(w_br, alu_add, br_geu));
		add_row("br_f3_2", encode(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, opc_branch), w_fb);
		add_row("jal", encode(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, opc_jal), w_jal);
		add_row("jalr", encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd3, opc_jalr), w_jalr);
		add_row("lui", encode(7'h12, 5'd4, 5'd5, 3'd6, 5'd3, opc_lui), w_lui);
		add_row("auipc", encode(7'h12, 5'd4, 5'd5, 3'd6, 5'd3, opc_auipc), w_auipc);
		add_row("op_ra0_0", encode(7'h00, 5'd2, 5'd0, 3'd0, 5'd3, opc_op), drop_enables(w_op, 3'b100));
		add_row("op_ra1_0", encode(7'h00, 5'd0, 5'd1, 3'd0, 5'd3, opc_op), drop_enables(w_op, 3'b010));
		add_row("op_wa_0", encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, opc_op), drop_enables(w_op, 3'b001));
		add_row("unknown_opc", encode(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h7f), w_fb);

		n = row_name.size();
		timeout_limit = n * 8 + 20;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_valid("reset", 1'b0, out_valid);
		check_ctrl("reset", '0, ctrl);

		idx       = 0;
		drv_valid = 1'b0;
		drv_stall = 1'b0;
		exp_valid = 1'b0;
		exp_ctrl  = '0;
		exp_name  = "reset";
		while (idx < n || drv_valid)
		begin
			@(posedge clk);
			if (!drv_stall) // this edge took what was offered
			begin
				exp_valid = drv_valid;
				if (drv_valid)
				begin
					exp_ctrl = row_exp[idx];
					exp_name = row_name[idx];
					idx++;
				end
			end
			rnd       = lcg_next();
			drv_valid = (idx < n);
			drv_stall = drv_valid && (rnd[17:16] == 2'b00);
			in_valid <= drv_valid;
			stall    <= drv_stall;
			if (drv_valid)
				inst <= row_inst[idx]; // held until accepted
			@(negedge clk);
			check_valid(exp_name, exp_valid, out_valid);
			check_ctrl(exp_name, exp_ctrl, ctrl);
		end

		// bubble clears valid, word stays
		@(posedge clk);
		@(negedge clk);
		check_valid("drain", 1'b0, out_valid);
		check_ctrl("drain", exp_ctrl, ctrl);

		$display("checks: %0d, value errors: %0d, assertion errors: %0d", checks, errors,
			u_dut.u_asserts.fail_count);
		if (errors == 0 && u_dut.u_asserts.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/rv_ctrl_pkg.sv
src/op_class_decoder.sv
src/funct_decoder.sv
src/ctrl_signal_gen.sv
src/decode_stage_reg.sv
src/ctrl_decode_top.sv
tests/ctrl_decode_asserts.sv
tests/ctrl_decode_tb.sv

// ==== Makefile ====
TOP := ctrl_decode_tb
RTL := $(shell grep '^src/' filelist.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(RTL) tests/ctrl_decode_tb.sv tests/ctrl_decode_asserts.sv
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only -Wall $(RTL) --top-module ctrl_decode_top

clean:
	rm -rf obj_dir
